/* source/ex_pkg.sv */
package ex_pkg;

    // Data, address and tag widths
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;

    // Link increments for full-size and compressed instructions
    localparam logic [XLEN-1:0] PC_STEP_FULL       = XLEN'(4);
    localparam logic [XLEN-1:0] PC_STEP_COMPRESSED = XLEN'(2);

    // ------------------------------------------------------------------------
    // Operation encoding shared by all fixed latency units
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD    = 5'd0,
        SUB    = 5'd1,
        AND    = 5'd2,
        OR     = 5'd3,
        XOR    = 5'd4,
        SLL    = 5'd5,
        SRL    = 5'd6,
        SRA    = 5'd7,
        SLT    = 5'd8,
        SLTU   = 5'd9,
        // Branch unit
        EQ     = 5'd10,
        NE     = 5'd11,
        LT     = 5'd12,
        GE     = 5'd13,
        LTU    = 5'd14,
        GEU    = 5'd15,
        JALR   = 5'd16,
        // CSR buffer
        CSR_OP = 5'd17,
        // Multiplier
        MUL    = 5'd18,
        MULH   = 5'd19,
        MULHU  = 5'd20
    } fu_op_t;

    // Operand B, either a plain data word or a CSR address field
    typedef union packed {
        logic [XLEN-1:0] word;
        struct packed {
            logic [XLEN-CSR_ADDR_BITS-1:0] unused;
            logic [CSR_ADDR_BITS-1:0]      csr_addr;
        } csr;
    } operand_b_u;

endpackage

/* source/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
    input  fu_op_t          alu_op_i,
    input  logic [XLEN-1:0] alu_a_i,
    input  logic [XLEN-1:0] alu_b_i,
    output logic [XLEN-1:0] alu_result_o,
    output logic            branch_cmp_o
);

    logic            negate;
    logic [XLEN:0]   adder_sum;
    logic            is_equal;
    logic            less_signed;
    logic            less_unsigned;
    logic [4:0]      shamt;

    // ------------------------------------------------------------------------
    // Shared adder subtracts for SUB and every comparison
    // ------------------------------------------------------------------------
    always_comb begin
        negate = 1'b1;
        if (alu_op_i == ADD) begin
            negate = 1'b0;
        end
    end

    assign adder_sum = {1'b0, alu_a_i} + {1'b0, alu_b_i ^ {XLEN{negate}}} + (XLEN + 1)'(negate);

    // Carry out of a - b is set when a >= b unsigned
    assign is_equal      = (adder_sum[XLEN-1:0] == '0);
    assign less_unsigned = ~adder_sum[XLEN];
    assign less_signed   = (alu_a_i[XLEN-1] == alu_b_i[XLEN-1]) ? adder_sum[XLEN-1]
                                                                 : alu_a_i[XLEN-1];

    assign shamt = alu_b_i[4:0];

    always_comb begin
        alu_result_o = adder_sum[XLEN-1:0];
        unique case (alu_op_i)
            AND:     alu_result_o = alu_a_i & alu_b_i;
            OR:      alu_result_o = alu_a_i | alu_b_i;
            XOR:     alu_result_o = alu_a_i ^ alu_b_i;
            SLL:     alu_result_o = alu_a_i << shamt;
            SRL:     alu_result_o = alu_a_i >> shamt;
            SRA:     alu_result_o = $unsigned($signed(alu_a_i) >>> shamt);
            SLT:     alu_result_o = {{(XLEN-1){1'b0}}, less_signed};
            SLTU:    alu_result_o = {{(XLEN-1){1'b0}}, less_unsigned};
            default: alu_result_o = adder_sum[XLEN-1:0];
        endcase
    end

    // Branch condition for the branch unit
    always_comb begin
        branch_cmp_o = 1'b0;
        unique case (alu_op_i)
            EQ:      branch_cmp_o = is_equal;
            NE:      branch_cmp_o = ~is_equal;
            LT:      branch_cmp_o = less_signed;
            GE:      branch_cmp_o = ~less_signed;
            LTU:     branch_cmp_o = less_unsigned;
            GEU:     branch_cmp_o = ~less_unsigned;
            default: branch_cmp_o = 1'b0;
        endcase
    end

endmodule

/* source/ex_branch_unit.sv */
`timescale 1ns/1ps

module ex_branch_unit import ex_pkg::*; (
    input  logic            branch_valid_i,
    input  fu_op_t          fu_op_i,
    input  logic [XLEN-1:0] operand_a_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            is_compressed_i,
    input  logic            branch_cmp_i,
    input  logic            predict_taken_i,
    input  logic [XLEN-1:0] predict_addr_i,
    output logic [XLEN-1:0] link_o,
    output logic            resolve_branch_o,
    output logic            resolved_taken_o,
    output logic [XLEN-1:0] resolved_target_o,
    output logic            mispredict_o
);

    logic            is_jalr;
    logic            taken;
    logic [XLEN-1:0] target_base;
    logic [XLEN-1:0] target_sum;
    logic [XLEN-1:0] target;
    logic            dir_wrong;
    logic            addr_wrong;

    assign is_jalr = (fu_op_i == JALR);

    // ------------------------------------------------------------------------
    // Target and link address
    // ------------------------------------------------------------------------
    // JALR jumps relative to rs1, conditional branches relative to the pc
    assign target_base = is_jalr ? operand_a_i : pc_i;
    assign target_sum  = target_base + imm_i;
    assign target      = is_jalr ? {target_sum[XLEN-1:1], 1'b0} : target_sum;

    assign link_o = pc_i + (is_compressed_i ? PC_STEP_COMPRESSED : PC_STEP_FULL);

    // ------------------------------------------------------------------------
    // Resolution
    // ------------------------------------------------------------------------
    assign taken = is_jalr | branch_cmp_i;

    assign resolve_branch_o  = branch_valid_i;
    assign resolved_taken_o  = branch_valid_i & taken;
    // Fall-through address when not taken
    assign resolved_target_o = taken ? target : link_o;

    // Direction or, when taken, address disagrees with the frontend
    assign dir_wrong  = (taken != predict_taken_i);
    assign addr_wrong = taken & (target != predict_addr_i);

    assign mispredict_o = branch_valid_i & (dir_wrong | addr_wrong);

endmodule

/* source/ex_csr_buffer.sv */
`timescale 1ns/1ps

module ex_csr_buffer import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     csr_valid_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_b_u               operand_b_i,
    input  logic                     csr_commit_i,
    output logic                     csr_ready_o,
    output logic [XLEN-1:0]          csr_result_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                     full_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;
    logic                     accept;

    // Commit frees the entry in the same cycle
    assign csr_ready_o = ~full_q | csr_commit_i;
    assign accept      = csr_valid_i & csr_ready_o;

    // Value goes to the scoreboard, the CSR file is written at commit
    assign csr_result_o = operand_a_i;
    assign csr_addr_o   = addr_q;

    // ------------------------------------------------------------------------
    // Occupancy flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (csr_commit_i) begin
            full_q <= 1'b0;
        end
    end

    // Address taken from the CSR view of operand B
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= operand_b_i.csr.csr_addr;
        end
    end

endmodule

/* source/ex_mult.sv */
`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     mult_valid_i,
    input  fu_op_t                   mult_op_i,
    input  logic [XLEN-1:0]          mult_a_i,
    input  logic [XLEN-1:0]          mult_b_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    output logic                     mult_valid_o,
    output logic [XLEN-1:0]          mult_result_o,
    output logic [TRANS_ID_BITS-1:0] mult_trans_id_o
);

    logic                     is_signed;
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] product;
    logic [XLEN-1:0]          result_d;

    logic                     valid_q;
    logic [XLEN-1:0]          result_q;
    logic [TRANS_ID_BITS-1:0] trans_id_q;

    // ------------------------------------------------------------------------
    // 33x33 signed product covers both signed and unsigned forms
    // ------------------------------------------------------------------------
    assign is_signed = (mult_op_i == MULH);
    assign a_ext     = {is_signed & mult_a_i[XLEN-1], mult_a_i};
    assign b_ext     = {is_signed & mult_b_i[XLEN-1], mult_b_i};
    assign product   = a_ext * b_ext;

    // MUL keeps the low word, MULH and MULHU the high word
    assign result_d = (mult_op_i == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= trans_id_i;
    end

    assign mult_valid_o    = valid_q;
    assign mult_result_o   = result_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

/* source/ex_flu_ctrl.sv */
`timescale 1ns/1ps

module ex_flu_ctrl import ex_pkg::*; (
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    input  fu_op_t                   fu_op_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_b_u               operand_b_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [XLEN-1:0]          alu_result_i,
    input  logic [XLEN-1:0]          link_i,
    input  logic [XLEN-1:0]          csr_result_i,
    input  logic                     csr_ready_i,
    input  logic [XLEN-1:0]          mult_result_i,
    input  logic                     mult_valid_i_r,
    input  logic [TRANS_ID_BITS-1:0] mult_trans_id_i,
    output fu_op_t                   alu_op_o,
    output logic [XLEN-1:0]          alu_a_o,
    output logic [XLEN-1:0]          alu_b_o,
    output fu_op_t                   mult_op_o,
    output logic [XLEN-1:0]          mult_a_o,
    output logic [XLEN-1:0]          mult_b_o,
    output logic                     flu_ready_o,
    output logic                     flu_valid_o,
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o
);

    logic alu_issue;
    logic mult_issue;
    logic single_issue;

    // Only the CSR buffer can stall the shared issue port
    assign flu_ready_o = csr_ready_i;

    assign alu_issue    = (alu_valid_i | branch_valid_i) & csr_ready_i;
    assign mult_issue   = mult_valid_i & csr_ready_i;
    assign single_issue = (alu_valid_i | branch_valid_i | csr_valid_i) & csr_ready_i;

    // ------------------------------------------------------------------------
    // Operand silencing
    // ------------------------------------------------------------------------
    assign alu_op_o = alu_issue ? fu_op_i : ADD;
    assign alu_a_o  = alu_issue ? operand_a_i : '0;
    assign alu_b_o  = alu_issue ? operand_b_i.word : '0;

    assign mult_op_o = mult_issue ? fu_op_i : MUL;
    assign mult_a_o  = mult_issue ? operand_a_i : '0;
    assign mult_b_o  = mult_issue ? operand_b_i.word : '0;

    // ------------------------------------------------------------------------
    // Write-back port
    // ------------------------------------------------------------------------
    // Issue logic keeps zero-latency ops out of the multiplier return slot
    assign flu_valid_o = single_issue | mult_valid_i_r;

    always_comb begin
        // Link address unless another source claims the port
        flu_result_o   = link_i;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i_r) begin
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

endmodule

/* source/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // Issue port
    input  fu_op_t                   fu_op_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_b_u               operand_b_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [XLEN-1:0]          pc_i,
    input  logic                     is_compressed_i,
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    output logic                     flu_ready_o,
    // Write-back port
    output logic                     flu_valid_o,
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,
    // Branch resolution
    input  logic                     predict_taken_i,
    input  logic [XLEN-1:0]          predict_addr_i,
    output logic                     resolve_branch_o,
    output logic                     resolved_taken_o,
    output logic [XLEN-1:0]          resolved_target_o,
    output logic                     mispredict_o,
    // CSR
    input  logic                     csr_commit_i,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    fu_op_t                   alu_op;
    fu_op_t                   mult_op;
    logic [XLEN-1:0]          alu_a;
    logic [XLEN-1:0]          alu_b;
    logic [XLEN-1:0]          mult_a;
    logic [XLEN-1:0]          mult_b;
    logic [XLEN-1:0]          alu_result;
    logic [XLEN-1:0]          link;
    logic [XLEN-1:0]          csr_result;
    logic [XLEN-1:0]          mult_result;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;
    logic                     branch_cmp;
    logic                     csr_ready;
    logic                     mult_valid;
    logic                     branch_issue;
    logic                     mult_issue;

    // Units only start on an accepted issue
    assign branch_issue = branch_valid_i & flu_ready_o;
    assign mult_issue   = mult_valid_i & flu_ready_o;

    // ------------------------------------------------------------------------
    // Shared issue and write-back control
    // ------------------------------------------------------------------------
    ex_flu_ctrl flu_ctrl_i (
        .alu_valid_i, .branch_valid_i, .csr_valid_i, .mult_valid_i,
        .fu_op_i, .operand_a_i, .operand_b_i, .trans_id_i,
        .alu_result_i    ( alu_result    ),
        .link_i          ( link          ),
        .csr_result_i    ( csr_result    ),
        .csr_ready_i     ( csr_ready     ),
        .mult_result_i   ( mult_result   ),
        .mult_valid_i_r  ( mult_valid    ),
        .mult_trans_id_i ( mult_trans_id ),
        .alu_op_o ( alu_op ), .alu_a_o ( alu_a ), .alu_b_o ( alu_b ),
        .mult_op_o ( mult_op ), .mult_a_o ( mult_a ), .mult_b_o ( mult_b ),
        .flu_ready_o, .flu_valid_o, .flu_result_o, .flu_trans_id_o
    );

    ex_alu alu_i (
        .alu_op_i ( alu_op ), .alu_a_i ( alu_a ), .alu_b_i ( alu_b ),
        .alu_result_o ( alu_result ),
        .branch_cmp_o ( branch_cmp )
    );

    // Branch unit sees the unsilenced operands, comparison comes from the ALU
    ex_branch_unit branch_unit_i (
        .branch_valid_i ( branch_issue ),
        .fu_op_i, .operand_a_i, .imm_i, .pc_i, .is_compressed_i,
        .branch_cmp_i   ( branch_cmp   ),
        .predict_taken_i, .predict_addr_i,
        .link_o         ( link         ),
        .resolve_branch_o, .resolved_taken_o, .resolved_target_o, .mispredict_o
    );

    ex_csr_buffer csr_buffer_i (
        .clk_i, .rst_ni, .flush_i, .csr_valid_i, .operand_a_i, .operand_b_i,
        .csr_commit_i,
        .csr_ready_o  ( csr_ready  ),
        .csr_result_o ( csr_result ),
        .csr_addr_o
    );

    ex_mult mult_i (
        .clk_i, .rst_ni, .flush_i,
        .mult_valid_i    ( mult_issue    ),
        .mult_op_i ( mult_op ), .mult_a_i ( mult_a ), .mult_b_i ( mult_b ),
        .trans_id_i,
        .mult_valid_o    ( mult_valid    ),
        .mult_result_o   ( mult_result   ),
        .mult_trans_id_o ( mult_trans_id )
    );

endmodule

/* test/ex_stage_assertions.sv */
`timescale 1ns/1ps

module ex_stage_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic alu_valid_i,
    input logic branch_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    input logic csr_commit_i,
    input logic flu_ready_o,
    input logic flu_valid_o,
    input logic resolve_branch_o
);

    // Issue selects are one-hot or idle
    one_issue_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i}))
        else $error("more than one issue valid high");

    // A buffered CSR op stalls the port until commit
    csr_stalls_port: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i && flu_ready_o && !flush_i |=> !flu_ready_o || csr_commit_i)
        else $error("issue port ready while CSR entry pending");

    mult_returns: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i && flu_ready_o && !flush_i |=> flu_valid_o)
        else $error("multiply result missing one cycle after issue");

    // A resolved branch writes its link address back in the same cycle
    branch_writes_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resolve_branch_o |-> flu_valid_o)
        else $error("branch resolved without write-back");

endmodule

bind ex_stage ex_stage_assertions assertions_i (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .flush_i          ( flush_i          ),
    .alu_valid_i      ( alu_valid_i      ),
    .branch_valid_i   ( branch_valid_i   ),
    .csr_valid_i      ( csr_valid_i      ),
    .mult_valid_i     ( mult_valid_i     ),
    .csr_commit_i     ( csr_commit_i     ),
    .flu_ready_o      ( flu_ready_o      ),
    .flu_valid_o      ( flu_valid_o      ),
    .resolve_branch_o ( resolve_branch_o )
);

/* test/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

    localparam int WORDS     = 13;
    localparam int MAX_TESTS = 64;
    localparam int MEM_WORDS = 1024;

    localparam logic [31:0] KIND_ALU        = 32'd1;
    localparam logic [31:0] KIND_BRANCH     = 32'd2;
    localparam logic [31:0] KIND_MULT       = 32'd3;
    localparam logic [31:0] KIND_CSR        = 32'd4;
    localparam logic [31:0] KIND_FLUSH_CSR  = 32'd5;
    localparam logic [31:0] KIND_FLUSH_MULT = 32'd6;

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     flush_i;
    fu_op_t                   fu_op_i;
    logic [XLEN-1:0]          operand_a_i;
    operand_b_u               operand_b_i;
    logic [XLEN-1:0]          imm_i;
    logic [TRANS_ID_BITS-1:0] trans_id_i;
    logic [XLEN-1:0]          pc_i;
    logic                     is_compressed_i;
    logic                     alu_valid_i;
    logic                     branch_valid_i;
    logic                     csr_valid_i;
    logic                     mult_valid_i;
    logic                     predict_taken_i;
    logic [XLEN-1:0]          predict_addr_i;
    logic                     csr_commit_i;
    logic                     flu_ready_o;
    logic                     flu_valid_o;
    logic [XLEN-1:0]          flu_result_o;
    logic [TRANS_ID_BITS-1:0] flu_trans_id_o;
    logic                     resolve_branch_o;
    logic                     resolved_taken_o;
    logic [XLEN-1:0]          resolved_target_o;
    logic                     mispredict_o;
    logic [CSR_ADDR_BITS-1:0] csr_addr_o;

    logic [31:0] vec [MEM_WORDS];
    int          num_tests;
    int          errors;
    int          failed_tests;
    bit          loaded;

    ex_stage dut_i (.*);

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] field(input int t, input int col);
        return vec[10'(t * WORDS + col)];
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_valids();
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        csr_valid_i    = 1'b0;
        mult_valid_i   = 1'b0;
        flush_i        = 1'b0;
        csr_commit_i   = 1'b0;
    endtask

    // Row columns kind op a b imm pc compressed pred_taken pred_addr tag
    task automatic drive_row(input int t);
        logic [31:0] op;
        logic [31:0] tag;
        logic [31:0] comp;
        logic [31:0] pred;
        op   = field(t, 1);
        tag  = field(t, 9);
        comp = field(t, 6);
        pred = field(t, 7);
        fu_op_i          = fu_op_t'(op[4:0]);
        operand_a_i      = field(t, 2);
        operand_b_i.word = field(t, 3);
        imm_i            = field(t, 4);
        pc_i             = field(t, 5);
        is_compressed_i  = comp[0];
        predict_taken_i  = pred[0];
        predict_addr_i   = field(t, 8);
        trans_id_i       = tag[2:0];
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!flu_ready_o && n < 10) begin
            @(negedge clk_i);
            n++;
        end
        if (!flu_ready_o) begin
            $display("issue port did not become ready within 10 cycles");
            errors++;
        end
    endtask

    task automatic report(input int t, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d kind %0d ok", t, field(t, 0));
        end else begin
            $display("test %0d kind %0d failed", t, field(t, 0));
            failed_tests++;
        end
    endtask

    // Zero-latency write-back shared by ALU, branch and CSR issues
    task automatic check_writeback(input int t);
        check_val("flu_valid_o", 32'(flu_valid_o), 32'd1);
        check_val("flu_result_o", flu_result_o, field(t, 10));
        check_val("flu_trans_id_o", 32'(flu_trans_id_o), field(t, 9));
    endtask

    // ------------------------------------------------------------------------
    // Test kinds
    // ------------------------------------------------------------------------
    task automatic run_single(input int t, input bit is_branch);
        int          errs_before;
        logic [31:0] flags;
        errs_before = errors;
        flags = field(t, 12);
        @(negedge clk_i);
        wait_ready();
        drive_row(t);
        alu_valid_i    = !is_branch;
        branch_valid_i = is_branch;
        #2;
        check_writeback(t);
        if (is_branch) begin
            check_val("resolve_branch_o", 32'(resolve_branch_o), 32'd1);
            check_val("resolved_taken_o", 32'(resolved_taken_o), 32'(flags[4]));
            check_val("resolved_target_o", resolved_target_o, field(t, 11));
            check_val("mispredict_o", 32'(mispredict_o), 32'(flags[0]));
        end
        @(negedge clk_i);
        clear_valids();
        report(t, errs_before);
    endtask

    task automatic run_mult(inout int t);
        int errs_before;
        bit done;
        errs_before = errors;
        done = 1'b0;
        @(negedge clk_i);
        wait_ready();
        drive_row(t);
        mult_valid_i = 1'b1;
        while (!done) begin
            @(negedge clk_i);
            if (t + 1 < num_tests && field(t + 1, 0) == KIND_MULT) begin
                drive_row(t + 1);
            end else begin
                clear_valids();
                done = 1'b1;
            end
            #2;
            check_writeback(t);
            report(t, errs_before);
            errs_before = errors;
            if (!done) begin
                t++;
            end
        end
    endtask

    // CSR issue, then either a held ADD until commit or a flush
    task automatic run_csr(input int t, input bit with_flush);
        int errs_before;
        errs_before = errors;
        @(negedge clk_i);
        wait_ready();
        drive_row(t);
        csr_valid_i = 1'b1;
        #2;
        check_writeback(t);
        check_val("flu_ready_o", 32'(flu_ready_o), 32'd1);
        @(negedge clk_i);
        csr_valid_i = 1'b0;
        if (with_flush) begin
            flush_i = 1'b1;
        end else begin
            fu_op_i     = ADD;
            alu_valid_i = 1'b1;
        end
        #2;
        check_val("csr_addr_o", 32'(csr_addr_o), field(t, 12));
        check_val("flu_ready_o", 32'(flu_ready_o), 32'd0);
        check_val("flu_valid_o", 32'(flu_valid_o), 32'd0);
        if (!with_flush) begin
            repeat (2) begin
                @(negedge clk_i);
                #2;
                check_val("flu_ready_o", 32'(flu_ready_o), 32'd0);
                check_val("flu_valid_o", 32'(flu_valid_o), 32'd0);
            end
            @(negedge clk_i);
            csr_commit_i = 1'b1;
            #2;
            check_val("flu_ready_o", 32'(flu_ready_o), 32'd1);
            check_val("flu_valid_o", 32'(flu_valid_o), 32'd1);
            check_val("flu_result_o", flu_result_o, field(t, 11));
        end
        @(negedge clk_i);
        clear_valids();
        #2;
        check_val("flu_ready_o", 32'(flu_ready_o), 32'd1);
        report(t, errs_before);
    endtask

    task automatic run_flush_mult(input int t);
        int errs_before;
        errs_before = errors;
        @(negedge clk_i);
        wait_ready();
        drive_row(t);
        mult_valid_i = 1'b1;
        flush_i      = 1'b1;
        @(negedge clk_i);
        clear_valids();
        #2;
        check_val("flu_valid_o", 32'(flu_valid_o), 32'd0);
        check_val("flu_ready_o", 32'(flu_ready_o), 32'd1);
        report(t, errs_before);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int t;
        errors       = 0;
        failed_tests = 0;
        rst_ni       = 1'b0;
        clear_valids();
        for (int i = 0; i < MEM_WORDS; i++) begin
            vec[10'(i)] = '0;
        end
        $readmemh("test/ex_stage_tests.txt", vec);
        drive_row(0);
        num_tests = 0;
        while (num_tests < MAX_TESTS && field(num_tests, 0) != 0) begin
            num_tests++;
        end
        loaded = 1'b1;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #2;
        check_val("flu_ready_o", 32'(flu_ready_o), 32'd1);
        check_val("flu_valid_o", 32'(flu_valid_o), 32'd0);
        check_val("resolve_branch_o", 32'(resolve_branch_o), 32'd0);
        check_val("mispredict_o", 32'(mispredict_o), 32'd0);

        t = 0;
        while (t < num_tests) begin
            case (field(t, 0))
                KIND_ALU:        run_single(t, 1'b0);
                KIND_BRANCH:     run_single(t, 1'b1);
                KIND_MULT:       run_mult(t);
                KIND_CSR:        run_csr(t, 1'b0);
                KIND_FLUSH_CSR:  run_csr(t, 1'b1);
                KIND_FLUSH_MULT: run_flush_mult(t);
                default: begin
                    $display("test %0d has an unknown kind %0d", t, field(t, 0));
                    errors++;
                    failed_tests++;
                end
            endcase
            t++;
        end

        @(negedge clk_i);
        if (num_tests == 0) begin
            $display("no tests were loaded from the test file");
            errors++;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", num_tests,
                 num_tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog allows about 20 cycles per test plus reset
    initial begin
        wait (loaded);
        repeat ((num_tests + 1) * 20) @(posedge clk_i);
        $display("timeout after %0d cycles, tests did not finish", (num_tests + 1) * 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* src.f */
source/ex_pkg.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_csr_buffer.sv
source/ex_mult.sv
source/ex_flu_ctrl.sv
source/ex_stage.sv
test/ex_stage_assertions.sv
test/ex_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module ex_stage_tb \
        -f src.f -o ex_stage_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/ex_stage_sim)"
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF '** PASS **' <<< "$sim_out"; then
    exit 0
fi
exit 1

/* test/ex_stage_tests.txt */
// kind op a b imm pc compressed pred_taken pred_addr tag exp_result exp_target exp_flags
// kind 1 alu, 2 branch, 3 mult (adjacent rows issue back to back), 4 csr, 5 flush csr,
// 6 flush mult; flags bit 4 taken, bit 0 mispredict, csr kinds hold the csr address;
// kind 4 exp_target is the ADD of a and b held while the CSR entry is pending
1 0 7fffffff 1 0 0 0 0 0 1 80000000 0 0
1 1 5 7 0 0 0 0 0 2 fffffffe 0 0
1 2 f0f0f0f0 0ff00ff0 0 0 0 0 0 3 00f000f0 0 0
1 3 f0f0f0f0 0ff00ff0 0 0 0 0 0 4 fff0fff0 0 0
1 4 f0f0f0f0 0ff00ff0 0 0 0 0 0 5 ff00ff00 0 0
1 5 1 24 0 0 0 0 0 6 10 0 0
1 6 80000000 4 0 0 0 0 0 7 08000000 0 0
1 7 80000000 4 0 0 0 0 0 0 f8000000 0 0
1 8 ffffffff 1 0 0 0 0 0 1 1 0 0
1 9 ffffffff 1 0 0 0 0 0 2 0 0 0
2 a 5 5 10 1000 0 1 1010 1 1004 1010 10
2 a 5 6 10 1000 1 1 1010 2 1002 1002 1
2 b 1 2 fffffff0 2000 0 1 1ff4 3 2004 1ff0 11
2 c ffffffff 1 20 3000 1 0 0 4 3002 3020 11
2 d ffffffff 1 20 3000 0 0 0 5 3004 3004 0
2 e ffffffff 1 8 4000 0 0 0 6 4004 4004 0
2 f ffffffff 1 8 4000 1 1 4008 7 4002 4008 10
2 10 8001 0 4 5000 1 1 8004 0 5002 8004 10
2 10 9000 0 3 5100 0 0 0 1 5104 9002 11
3 12 7fffffff 7fffffff 0 0 0 0 0 3 1 0 0
3 13 80000000 80000000 0 0 0 0 0 4 40000000 0 0
3 14 ffffffff ffffffff 0 0 0 0 0 5 fffffffe 0 0
4 11 cafef00d abcde305 0 0 0 0 0 2 cafef00d 76ccd312 305
3 14 80000000 2 0 0 0 0 0 1 1 0 0
5 11 11111111 342 0 0 0 0 0 3 11111111 0 342
6 12 3 4 0 0 0 0 0 4 0 0 0
3 13 ffffffff 2 0 0 0 0 0 6 ffffffff 0 0
3 12 12345678 10 0 0 0 0 0 7 23456780 0 0
1 0 1 ffffffff 0 0 0 0 0 5 0 0 0
